/* design/alu_pkg.sv */
package alu_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 8;
    localparam int PIPELINE_DEPTH = 5;

    // Bit position and population count widths for the logic lane
    localparam int BIT_POS_WIDTH = $clog2(DATA_WIDTH);
    localparam int POPCNT_WIDTH = $clog2(DATA_WIDTH) + 1;

    typedef enum logic [7:0] {
        LAND   = 8'h00,
        LOR    = 8'h01,
        LNOT   = 8'h02,
        POPCNT = 8'h03,
        ABS    = 8'h04,
        BSET   = 8'h05,
        BCLR   = 8'h06,
        BINV   = 8'h07,
        BSEL   = 8'h08,
        BGT    = 8'h10,
        BLE    = 8'h11,
        BEQ    = 8'h12,
        BNE    = 8'h13,
        SATP   = 8'h18,
        SATN   = 8'h19,
        LDR    = 8'h20,
        LDC    = 8'h21
    } opcode_t;

    typedef enum logic [1:0] {
        LANE_LOGIC,
        LANE_COMPARE,
        LANE_SATURATE,
        LANE_LOAD
    } lane_t;

    localparam int N_LANES = 4;

    // Dispatch and the selector take one cycle each, and the lane's own latency
    // plus these padding stages makes up the rest
    localparam int LANE_DELAY [N_LANES] = '{
        PIPELINE_DEPTH - 3,
        PIPELINE_DEPTH - 3,
        PIPELINE_DEPTH - 4,
        PIPELINE_DEPTH - 2
    };

    typedef struct packed {
        logic                      valid;
        opcode_t                   opcode;
        logic [DATA_WIDTH-1:0]     operand_a;
        logic [DATA_WIDTH-1:0]     operand_b;
        logic [REG_ADDR_WIDTH-1:0] dest;
    } alu_request_t;

    typedef struct packed {
        logic                      valid;
        logic [DATA_WIDTH-1:0]     data;
        logic [REG_ADDR_WIDTH-1:0] dest;
    } alu_result_t;

    // Ordering of single precision values taken as plain sign-magnitude numbers
    function automatic logic fp_greater(input logic [DATA_WIDTH-1:0] a,
                                        input logic [DATA_WIDTH-1:0] b);
        logic                  sign_a;
        logic                  sign_b;
        logic [DATA_WIDTH-2:0] mag_a;
        logic [DATA_WIDTH-2:0] mag_b;
        logic                  greater;
        sign_a = a[DATA_WIDTH-1];
        sign_b = b[DATA_WIDTH-1];
        mag_a = a[DATA_WIDTH-2:0];
        mag_b = b[DATA_WIDTH-2:0];
        if (sign_a != sign_b) begin
            greater = !sign_a;
        end else if (!sign_a) begin
            greater = mag_a > mag_b;
        end else begin
            // Both negative, so the smaller magnitude is the larger value
            greater = mag_a < mag_b;
        end
        return greater;
    endfunction

endpackage

/* design/alu_dispatch.sv */
`timescale 1ns/100ps

module alu_dispatch import alu_pkg::*; (
    input  logic         clock,
    input  logic         arst_n,
    input  alu_request_t request,
    output alu_request_t logic_request,
    output alu_request_t compare_request,
    output alu_request_t saturate_request,
    output alu_result_t  load_result
);

    lane_t                 lane;
    logic                  known_opcode;
    logic [N_LANES-1:0]    lane_valid_q;
    alu_request_t          request_q;
    logic [DATA_WIDTH-1:0] load_data_q;

    always_comb begin
        lane = LANE_LOGIC;
        known_opcode = 1'b1;
        case (request.opcode)
            LAND, LOR, LNOT, POPCNT, ABS, BSET, BCLR, BINV, BSEL: lane = LANE_LOGIC;
            BGT, BLE, BEQ, BNE: lane = LANE_COMPARE;
            SATP, SATN: lane = LANE_SATURATE;
            LDR, LDC: lane = LANE_LOAD;
            default: known_opcode = 1'b0;
        endcase
    end

    // The lane strobe is one hot and stays all low for an invalid opcode
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            lane_valid_q <= '0;
        end else begin
            lane_valid_q <= '0;
            if (request.valid && known_opcode) begin
                lane_valid_q[lane] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        request_q <= request;
        load_data_q <= (request.opcode == LDC) ? request.operand_b : request.operand_a;
    end

    always_comb begin
        logic_request = request_q;
        logic_request.valid = lane_valid_q[LANE_LOGIC];
        compare_request = request_q;
        compare_request.valid = lane_valid_q[LANE_COMPARE];
        saturate_request = request_q;
        saturate_request.valid = lane_valid_q[LANE_SATURATE];
    end

    // Loads need no lane of their own because the write-back is ready here
    assign load_result = '{valid: lane_valid_q[LANE_LOAD], data: load_data_q,
                           dest: request_q.dest};

endmodule

/* design/logic_unit.sv */
`timescale 1ns/100ps

module logic_unit import alu_pkg::*; (
    input  logic         clock,
    input  logic         arst_n,
    input  alu_request_t logic_request,
    output alu_result_t  logic_result
);

    logic [DATA_WIDTH-1:0]     a;
    logic [DATA_WIDTH-1:0]     b;
    logic [BIT_POS_WIDTH-1:0]  pos;
    logic [DATA_WIDTH-1:0]     bit_mask;
    logic [POPCNT_WIDTH-1:0]   ones;
    logic [DATA_WIDTH-1:0]     data_d;
    logic                      valid_q;
    logic [DATA_WIDTH-1:0]     data_q;
    logic [REG_ADDR_WIDTH-1:0] dest_q;

    assign a = logic_request.operand_a;
    assign b = logic_request.operand_b;

    // Bit operations only look at the low bits of operand b
    assign pos = b[BIT_POS_WIDTH-1:0];
    assign bit_mask = DATA_WIDTH'(1) << pos;

    always_comb begin
        ones = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            ones = ones + POPCNT_WIDTH'(a[i]);
        end
    end

    always_comb begin
        case (logic_request.opcode)
            LAND:    data_d = a & b;
            LOR:     data_d = a | b;
            LNOT:    data_d = ~a;
            POPCNT:  data_d = DATA_WIDTH'(ones);
            ABS:     data_d = {1'b0, a[DATA_WIDTH-2:0]};
            BSET:    data_d = a | bit_mask;
            BCLR:    data_d = a & ~bit_mask;
            BINV:    data_d = a ^ bit_mask;
            BSEL:    data_d = DATA_WIDTH'(a[pos]);
            default: data_d = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= logic_request.valid;
        end
    end

    always_ff @(posedge clock) begin
        data_q <= data_d;
        dest_q <= logic_request.dest;
    end

    assign logic_result = '{valid: valid_q, data: data_q, dest: dest_q};

endmodule

/* design/fp_compare_unit.sv */
`timescale 1ns/100ps

module fp_compare_unit import alu_pkg::*; (
    input  logic         clock,
    input  logic         arst_n,
    input  alu_request_t compare_request,
    output alu_result_t  compare_result
);

    logic                      a_greater;
    logic                      same_bits;
    logic                      flag;
    logic                      valid_q;
    logic [DATA_WIDTH-1:0]     data_q;
    logic [REG_ADDR_WIDTH-1:0] dest_q;

    assign a_greater = fp_greater(compare_request.operand_a, compare_request.operand_b);

    // Equality is on bit patterns, so +0 and -0 differ
    assign same_bits = compare_request.operand_a == compare_request.operand_b;

    always_comb begin
        case (compare_request.opcode)
            BGT:     flag = a_greater;
            BLE:     flag = !a_greater;
            BEQ:     flag = same_bits;
            BNE:     flag = !same_bits;
            default: flag = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= compare_request.valid;
        end
    end

    always_ff @(posedge clock) begin
        data_q <= DATA_WIDTH'(flag);
        dest_q <= compare_request.dest;
    end

    assign compare_result = '{valid: valid_q, data: data_q, dest: dest_q};

endmodule

/* design/fp_saturator.sv */
`timescale 1ns/100ps

module fp_saturator import alu_pkg::*; (
    input  logic         clock,
    input  logic         arst_n,
    input  alu_request_t saturate_request,
    output alu_result_t  saturate_result
);

    // Stage one
    logic                      valid_s1;
    logic [DATA_WIDTH-1:0]     a_s1;
    logic [DATA_WIDTH-1:0]     b_s1;
    opcode_t                   opcode_s1;
    logic [REG_ADDR_WIDTH-1:0] dest_s1;
    logic                      a_greater_s1;

    // Stage two
    logic                      valid_s2;
    logic [DATA_WIDTH-1:0]     data_s2;
    logic [REG_ADDR_WIDTH-1:0] dest_s2;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= saturate_request.valid;
            valid_s2 <= valid_s1;
        end
    end

    always_ff @(posedge clock) begin
        a_s1 <= saturate_request.operand_a;
        b_s1 <= saturate_request.operand_b;
        opcode_s1 <= saturate_request.opcode;
        dest_s1 <= saturate_request.dest;
        a_greater_s1 <= fp_greater(saturate_request.operand_a, saturate_request.operand_b);
    end

    // The ordering is total on bit patterns, so when a is not above b either
    // b is above a or both are equal, and then b is the right answer too
    always_ff @(posedge clock) begin
        if (opcode_s1 == SATP) begin
            data_s2 <= a_greater_s1 ? b_s1 : a_s1;
        end else begin
            data_s2 <= a_greater_s1 ? a_s1 : b_s1;
        end
        dest_s2 <= dest_s1;
    end

    assign saturate_result = '{valid: valid_s2, data: data_s2, dest: dest_s2};

endmodule

/* design/pipeline_delay.sv */
`timescale 1ns/100ps

module pipeline_delay import alu_pkg::*; #(
    parameter int N_STAGES = 1
) (
    input  logic        clock,
    input  logic        arst_n,
    input  alu_result_t in_result,
    output alu_result_t out_result
);

    logic [N_STAGES-1:0]       valid_q;
    logic [DATA_WIDTH-1:0]     data_q [N_STAGES];
    logic [REG_ADDR_WIDTH-1:0] dest_q [N_STAGES];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_result.valid;
            for (int i = 1; i < N_STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        data_q[0] <= in_result.data;
        dest_q[0] <= in_result.dest;
        for (int i = 1; i < N_STAGES; i++) begin
            data_q[i] <= data_q[i-1];
            dest_q[i] <= dest_q[i-1];
        end
    end

    assign out_result = '{valid: valid_q[N_STAGES-1], data: data_q[N_STAGES-1],
                          dest: dest_q[N_STAGES-1]};

endmodule

/* design/result_select.sv */
`timescale 1ns/100ps

module result_select import alu_pkg::*; (
    input  logic        clock,
    input  logic        arst_n,
    input  alu_result_t aligned_results [N_LANES],
    output alu_result_t result
);

    alu_result_t               picked;
    logic                      valid_q;
    logic [DATA_WIDTH-1:0]     data_q;
    logic [REG_ADDR_WIDTH-1:0] dest_q;

    // At most one lane is valid in any cycle, so the last match is the only one
    always_comb begin
        picked = '0;
        for (int i = 0; i < N_LANES; i++) begin
            if (aligned_results[i].valid) begin
                picked = aligned_results[i];
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= picked.valid;
        end
    end

    always_ff @(posedge clock) begin
        data_q <= picked.data;
        dest_q <= picked.dest;
    end

    assign result = '{valid: valid_q, data: data_q, dest: dest_q};

endmodule

/* design/fp_alu.sv */
`timescale 1ns/100ps

module fp_alu import alu_pkg::*; (
    input  logic         clock,
    input  logic         arst_n,
    input  alu_request_t request,
    output alu_result_t  result
);

    alu_request_t logic_request;
    alu_request_t compare_request;
    alu_request_t saturate_request;
    alu_result_t  lane_results [N_LANES];
    alu_result_t  aligned_results [N_LANES];

    alu_dispatch u_dispatch (
        .clock            (clock),
        .arst_n           (arst_n),
        .request          (request),
        .logic_request    (logic_request),
        .compare_request  (compare_request),
        .saturate_request (saturate_request),
        .load_result      (lane_results[LANE_LOAD])
    );

    logic_unit u_logic (
        .clock         (clock),
        .arst_n        (arst_n),
        .logic_request (logic_request),
        .logic_result  (lane_results[LANE_LOGIC])
    );

    fp_compare_unit u_compare (
        .clock           (clock),
        .arst_n          (arst_n),
        .compare_request (compare_request),
        .compare_result  (lane_results[LANE_COMPARE])
    );

    fp_saturator u_saturate (
        .clock            (clock),
        .arst_n           (arst_n),
        .saturate_request (saturate_request),
        .saturate_result  (lane_results[LANE_SATURATE])
    );

    // Pad each lane so all of them reach the selector in the same cycle
    for (genvar i = 0; i < N_LANES; i++) begin : g_lane_delay
        pipeline_delay #(
            .N_STAGES (LANE_DELAY[i])
        ) u_delay (
            .clock      (clock),
            .arst_n     (arst_n),
            .in_result  (lane_results[i]),
            .out_result (aligned_results[i])
        );
    end

    result_select u_select (
        .clock           (clock),
        .arst_n          (arst_n),
        .aligned_results (aligned_results),
        .result          (result)
    );

endmodule

/* tb/fp_alu_sva.sv */
`timescale 1ns/100ps

module fp_alu_sva import alu_pkg::*; (
    input logic        clock,
    input logic        arst_n,
    input alu_result_t aligned_results [N_LANES],
    input alu_result_t result
);

    logic [N_LANES-1:0] lane_valid;

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            lane_valid[i] = aligned_results[i].valid;
        end
    end

    // Dispatch sends each request down a single lane
    lane_exclusive: assert property (
        @(posedge clock) disable iff (!arst_n) $onehot0(lane_valid)
    ) else $error("More than one aligned lane is valid in the same cycle");

    result_low_in_reset: assert property (
        @(posedge clock) !arst_n |-> !result.valid
    ) else $error("result.valid is high while reset is asserted");

    // The selector is a single register stage
    select_latency: assert property (
        @(posedge clock) disable iff (!arst_n) result.valid == $past(|lane_valid)
    ) else $error("result.valid does not follow the lane valids one cycle later");

endmodule

bind result_select fp_alu_sva u_sva (
    .clock           (clock),
    .arst_n          (arst_n),
    .aligned_results (aligned_results),
    .result          (result)
);

/* tb/fp_alu_tb.sv */
`timescale 1ns/100ps

module fp_alu_tb import alu_pkg::*; ();

    // Edges from the drive point to the visible result
    localparam int LATENCY = 5;

    logic         clock = 1'b0;
    logic         arst_n;
    alu_request_t request;
    alu_result_t  result;
    int unsigned  cycle_count = 0;

    logic [31:0] exp_data_q [$];
    logic [7:0]  exp_dest_q [$];
    int unsigned exp_cycle_q [$];
    string       exp_test_q [$];

    opcode_t all_opcodes [17] = '{LAND, LOR, LNOT, POPCNT, ABS, BSET, BCLR, BINV, BSEL,
                                  BGT, BLE, BEQ, BNE, SATP, SATN, LDR, LDC};

    fp_alu dut (
        .clock   (clock),
        .arst_n  (arst_n),
        .request (request),
        .result  (result)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s: expected 0x%0h actual 0x%0h", what, expected, actual);
            abort_run("A DUT response differs from the reference model");
        end
    endtask

    // Maps sign-magnitude patterns onto unsigned keys in the same order
    function automatic logic [31:0] order_key(input logic [31:0] x);
        return x[31] ? ~x : (x ^ 32'h8000_0000);
    endfunction

    function automatic logic ordered_above(input logic [31:0] a, input logic [31:0] b);
        return order_key(a) > order_key(b);
    endfunction

    function automatic logic is_known(input logic [7:0] op);
        logic known;
        known = 1'b0;
        foreach (all_opcodes[i]) begin
            if (all_opcodes[i] == op) begin
                known = 1'b1;
            end
        end
        return known;
    endfunction

    function automatic logic [31:0] model_data(input logic [7:0] op, input logic [31:0] a,
                                               input logic [31:0] b);
        logic [31:0] bit_at;
        bit_at = 32'd1 << b[4:0];
        case (op)
            LAND:    return a & b;
            LOR:     return a | b;
            LNOT:    return ~a;
            POPCNT:  return $countones(a);
            ABS:     return a & 32'h7fff_ffff;
            BSET:    return a | bit_at;
            BCLR:    return a & ~bit_at;
            BINV:    return a ^ bit_at;
            BSEL:    return ((a & bit_at) != 0) ? 32'd1 : 32'd0;
            BGT:     return ordered_above(a, b) ? 32'd1 : 32'd0;
            BLE:     return ordered_above(a, b) ? 32'd0 : 32'd1;
            BEQ:     return (a == b) ? 32'd1 : 32'd0;
            BNE:     return (a != b) ? 32'd1 : 32'd0;
            SATP:    return ordered_above(a, b) ? b : a;
            SATN:    return ordered_above(b, a) ? b : a;
            LDR:     return a;
            default: return b;
        endcase
    endfunction

    // Drives one request for one cycle and records what should come back
    task automatic send(input string name, input logic [7:0] op, input logic [31:0] a,
                        input logic [31:0] b, input logic [7:0] dest);
        @(posedge clock);
        #2;
        request = '{valid: 1'b1, opcode: opcode_t'(op), operand_a: a, operand_b: b,
                    dest: dest};
        if (is_known(op)) begin
            exp_data_q.push_back(model_data(op, a, b));
            exp_dest_q.push_back(dest);
            exp_cycle_q.push_back(cycle_count + LATENCY);
            exp_test_q.push_back(name);
        end
    endtask

    task automatic go_idle();
        @(posedge clock);
        #2;
        request.valid = 1'b0;
    endtask

    task automatic wait_drain(input int max_cycles);
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0) begin
            if (waited >= max_cycles) begin
                abort_run("Timed out waiting for outstanding results");
            end else begin
                @(posedge clock);
                waited++;
            end
        end
        // A few idle slots so a stray result is still caught by the monitor
        for (int i = 0; i < 3; i++) begin
            @(posedge clock);
        end
    endtask

    always @(negedge clock) begin
        if (arst_n && result.valid) begin
            if (exp_data_q.size() == 0) begin
                abort_run("A valid result appeared with no request outstanding");
            end else begin
                check_value({exp_test_q[0], " data"}, exp_data_q[0], result.data);
                check_value({exp_test_q[0], " dest"}, exp_dest_q[0], result.dest);
                check_value({exp_test_q[0], " arrival cycle"}, exp_cycle_q[0], cycle_count);
                void'(exp_data_q.pop_front());
                void'(exp_dest_q.pop_front());
                void'(exp_cycle_q.pop_front());
                void'(exp_test_q.pop_front());
            end
        end
    end

    task automatic test_reset();
        for (int i = 0; i < 5; i++) begin
            @(posedge clock);
            #2;
            check_value("test_reset in reset", 0, result.valid);
        end
        arst_n = 1'b1;
        for (int i = 0; i < 8; i++) begin
            @(posedge clock);
            #2;
            check_value("test_reset idle", 0, result.valid);
        end
    endtask

    task automatic test_logic();
        send("test_logic", LAND, 32'hf0f0_1234, 32'h0ff0_ffff, 8'h01);
        send("test_logic", LOR, 32'hf0f0_1234, 32'h0ff0_0001, 8'h02);
        send("test_logic", LNOT, 32'h1234_abcd, 32'h0, 8'h03);
        send("test_logic", POPCNT, 32'hffff_ffff, 32'h0, 8'h04);
        send("test_logic", POPCNT, 32'h0, 32'h0, 8'h05);
        send("test_logic", ABS, 32'hc048_f5c3, 32'h0, 8'h06);
        send("test_logic", BSET, 32'h0, 32'd0, 8'h07);
        send("test_logic", BSET, 32'h0, 32'd31, 8'h08);
        send("test_logic", BCLR, 32'hffff_ffff, 32'd0, 8'h09);
        send("test_logic", BCLR, 32'hffff_ffff, 32'd31, 8'h0a);
        send("test_logic", BINV, 32'h8000_0001, 32'd0, 8'h0b);
        send("test_logic", BINV, 32'h8000_0001, 32'd31, 8'h0c);
        send("test_logic", BSEL, 32'h8000_0001, 32'd31, 8'h0d);
        send("test_logic", BSEL, 32'h8000_0001, 32'd1, 8'h0e);
        send("test_logic", BSEL, 32'h8000_0001, 32'hffff_ffe0, 8'h0f);
        for (int i = 0; i < 9; i++) begin
            send("test_logic", all_opcodes[i], $urandom, $urandom, 8'(8'h40 + i));
        end
        go_idle();
        wait_drain(20);
    endtask

    task automatic test_compare();
        logic [31:0] lhs [9] = '{32'h4000_0000, 32'h3f80_0000, 32'h3f80_0000, 32'hbf80_0000,
                                 32'hc000_0000, 32'hbf80_0000, 32'h3f80_0000, 32'h0000_0000,
                                 32'h8000_0000};
        logic [31:0] rhs [9] = '{32'h3f80_0000, 32'h4000_0000, 32'h3f80_0000, 32'hc000_0000,
                                 32'hbf80_0000, 32'h3f80_0000, 32'hbf80_0000, 32'h8000_0000,
                                 32'h0000_0000};
        for (int i = 0; i < 9; i++) begin
            for (int k = 9; k < 13; k++) begin
                send("test_compare", all_opcodes[k], lhs[i], rhs[i], 8'(i * 4 + k));
            end
        end
        go_idle();
        wait_drain(20);
    endtask

    task automatic test_saturate();
        // Operand a is held against the limit in b, both as single precision values
        logic [31:0] value [7] = '{32'h4040_0000, 32'h3f80_0000, 32'h4000_0000, 32'hc040_0000,
                                   32'hbf80_0000, 32'h3f80_0000, 32'hc0a0_0000};
        logic [31:0] limit [7] = '{32'h4000_0000, 32'h4000_0000, 32'h4000_0000, 32'hc000_0000,
                                   32'hc000_0000, 32'hc000_0000, 32'h3f80_0000};
        for (int i = 0; i < 7; i++) begin
            send("test_saturate", SATP, value[i], limit[i], 8'(8'h80 + i));
            send("test_saturate", SATN, value[i], limit[i], 8'(8'h90 + i));
        end
        go_idle();
        wait_drain(20);
    endtask

    task automatic test_load_and_invalid();
        send("test_load_and_invalid", LDR, 32'hdead_beef, 32'h0000_0001, 8'h3c);
        send("test_load_and_invalid", LDC, 32'h0000_0001, 32'hcafe_0042, 8'hc3);
        send("test_load_and_invalid", 8'hff, 32'h1111_1111, 32'h2222_2222, 8'h55);
        send("test_load_and_invalid", LDR, 32'h0bad_f00d, 32'h0, 8'h00);
        send("test_load_and_invalid", 8'h09, 32'h3333_3333, 32'h4444_4444, 8'haa);
        send("test_load_and_invalid", LDC, 32'h0, 32'h7fff_ffff, 8'hff);
        go_idle();
        wait_drain(20);
    endtask

    task automatic test_stream();
        for (int i = 0; i < 200; i++) begin
            send("test_stream", all_opcodes[$urandom % 17], $urandom, $urandom, 8'($urandom));
        end
        go_idle();
        wait_drain(20);
    endtask

    initial begin
        void'($urandom(32'h44e3f085));
        arst_n = 1'b0;
        request = '0;
        test_reset();
        test_logic();
        test_compare();
        test_saturate();
        test_load_and_invalid();
        test_stream();
        $display("** PASS **");
        $finish;
    end

endmodule

/* fp_alu.f */
design/alu_pkg.sv
design/alu_dispatch.sv
design/logic_unit.sv
design/fp_compare_unit.sv
design/fp_saturator.sv
design/pipeline_delay.sv
design/result_select.sv
design/fp_alu.sv
tb/fp_alu_sva.sv
tb/fp_alu_tb.sv

/* Makefile */
OBJ_DIR = obj_dir

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f fp_alu.f --top-module fp_alu_tb --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vfp_alu_tb

lint:
	verilator --lint-only -Wall design/alu_pkg.sv design/alu_dispatch.sv design/logic_unit.sv \
		design/fp_compare_unit.sv design/fp_saturator.sv design/pipeline_delay.sv \
		design/result_select.sv design/fp_alu.sv --top-module fp_alu

clean:
	rm -rf $(OBJ_DIR)
